/* hw/mem_pkg.sv */
// Shared memory types and sizes for the fetch subsystem, referenced by scoped name from each block
package mem_pkg;

    //////////////////////////////
    // Basic bus types
    //////////////////////////////

    typedef logic [31:0] addr_t;      // Byte address, bits 2..0 are block offset
    typedef logic [63:0] mem_block_t; // One memory block, also one cache line
    typedef logic [3:0]  mem_tag_t;   // Transaction tag, zero means nothing

    // Memory command on every request path
    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } mem_command_t;

    //////////////////////////////
    // Memory geometry
    //////////////////////////////

    localparam int mem_depth      = 256;              // Blocks in the memory
    localparam int mem_index_bits = $clog2(mem_depth); // Block index is addr bits 10..3
    localparam int block_offset   = 3;                // Byte offset bits inside a block

    // Cycles from acceptance to return, kept below 15 so tags never wrap onto live loads
    localparam int mem_latency = 8;

    localparam mem_tag_t max_tag = 4'd15; // Highest tag before wrapping back to 1

    //////////////////////////////
    // Instruction cache geometry
    //////////////////////////////

    localparam int cache_lines      = 32;
    localparam int cache_index_bits = 5; // Addr bits 7..3
    localparam int cache_tag_bits   = 8; // Addr bits 15..8

endpackage

/* hw/icache.sv */
// Blocking direct-mapped instruction cache; fetch side sees hits combinationally, misses go to memory
`timescale 1ns/1ps

module icache (
    input  logic                 clock,
    input  logic                 reset,

    // Fetch side
    input  mem_pkg::addr_t       fetch_addr,    // Held by fetch source
    output mem_pkg::mem_block_t  fetch_data,    // Line at fetch_addr index
    output logic                 fetch_valid,   // Line valid and tag match

    // Request path to arbiter
    output mem_pkg::mem_command_t icache_command,
    output mem_pkg::addr_t       icache_addr,
    input  mem_pkg::mem_tag_t    icache_grant_tag, // Nonzero only when accepted

    // Memory return broadcast
    input  mem_pkg::mem_block_t  return_data,
    input  mem_pkg::mem_tag_t    return_tag
);

    // One cache line
    typedef struct packed {
        mem_pkg::mem_block_t                 data;
        logic [mem_pkg::cache_tag_bits-1:0]  tag;
        logic                                valid;
    } icache_entry_t;

    icache_entry_t lines [mem_pkg::cache_lines];

    //////////////////////////////
    // Address split
    //////////////////////////////

    logic [mem_pkg::cache_index_bits-1:0] current_index, last_index;
    logic [mem_pkg::cache_tag_bits-1:0]   current_tag, last_tag; // Cache tags, not memory tags

    assign current_index = fetch_addr[mem_pkg::block_offset +: mem_pkg::cache_index_bits];
    assign current_tag   = fetch_addr[mem_pkg::block_offset + mem_pkg::cache_index_bits +:
                                      mem_pkg::cache_tag_bits];

    assign fetch_data  = lines[current_index].data;
    assign fetch_valid = lines[current_index].valid &&
                         (lines[current_index].tag == current_tag); // Same-cycle hit

    //////////////////////////////
    // Miss tracking
    //////////////////////////////

    mem_pkg::mem_tag_t current_mem_tag;  // Memory tag of the miss in flight
    logic              miss_outstanding; // Still waiting for a grant tag

    logic changed_addr;
    logic got_mem_data;
    logic update_mem_tag;
    logic unanswered_miss;

    assign changed_addr = (current_index != last_index) || (current_tag != last_tag);
    assign got_mem_data = (current_mem_tag == return_tag) && (current_mem_tag != '0);

    // Grant tag is zero whenever we are not requesting, which clears the held tag
    assign update_mem_tag = changed_addr || miss_outstanding || got_mem_data;

    // New miss on fresh address, or previous request lost arbitration
    assign unanswered_miss = changed_addr ? !fetch_valid
                                          : miss_outstanding && (icache_grant_tag == '0);

    // Re-request every cycle until granted, drop it on an address change
    assign icache_command = (miss_outstanding && !changed_addr) ? mem_pkg::bus_load
                                                                : mem_pkg::bus_none;
    assign icache_addr    = {fetch_addr[31:mem_pkg::block_offset], {mem_pkg::block_offset{1'b0}}};

    //////////////////////////////
    // State and fill
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            last_index       <= '1; // All ones so first address looks changed
            last_tag         <= '1;
            current_mem_tag  <= '0;
            miss_outstanding <= 1'b0;
            for (int i = 0; i < mem_pkg::cache_lines; i++) begin
                lines[i].valid <= 1'b0; // Data and tag left as is
            end
        end else begin
            last_index       <= current_index;
            last_tag         <= current_tag;
            miss_outstanding <= unanswered_miss;
            if (update_mem_tag) begin
                current_mem_tag <= icache_grant_tag;
            end
            // Fill only the line the miss was raised for
            if (got_mem_data && !changed_addr) begin
                lines[current_index].data  <= return_data;
                lines[current_index].tag   <= current_tag;
                lines[current_index].valid <= 1'b1;
            end
        end
    end

    // Read-only client, so a grant only ever answers a load
    grant_only_on_load: assert property (@(posedge clock) disable iff (reset)
        icache_grant_tag != '0 |-> icache_command == mem_pkg::bus_load)
        else $error("icache_grant_tag %h without a load request", icache_grant_tag);

endmodule

/* hw/data_port.sv */
// Blocking uncached load/store port; takes one request, holds it until granted, reports done
`timescale 1ns/1ps

module data_port (
    input  logic                  clock,
    input  logic                  reset,

    // Requester side
    input  mem_pkg::mem_command_t data_command, // One-cycle request strobe
    input  mem_pkg::addr_t        data_addr,
    input  mem_pkg::mem_block_t   data_wdata,
    output mem_pkg::mem_block_t   data_rdata,   // Valid from done cycle of a load
    output logic                  data_busy,
    output logic                  data_done,

    // Request path to arbiter
    output mem_pkg::mem_command_t port_command,
    output mem_pkg::addr_t        port_addr,
    output mem_pkg::mem_block_t   port_wdata,
    input  mem_pkg::mem_tag_t     port_grant_tag,

    // Memory return broadcast
    input  mem_pkg::mem_block_t   return_data,
    input  mem_pkg::mem_tag_t     return_tag
);

    typedef enum logic [1:0] {
        port_idle,       // Free for a new request
        port_requesting, // Command on bus, waiting for grant
        port_awaiting    // Load granted, waiting for data
    } port_state_t;

    port_state_t           state;
    mem_pkg::mem_tag_t     held_tag;    // Tag of the outstanding load
    mem_pkg::mem_command_t req_command; // Registered request
    mem_pkg::addr_t        req_addr;
    mem_pkg::mem_block_t   req_wdata;

    logic granted;
    logic data_back;

    assign granted   = (state == port_requesting) && (port_grant_tag != '0);
    assign data_back = (state == port_awaiting) && (return_tag == held_tag);

    assign data_busy    = (state != port_idle);
    assign port_command = (state == port_requesting) ? req_command : mem_pkg::bus_none;
    assign port_addr    = {req_addr[31:mem_pkg::block_offset], {mem_pkg::block_offset{1'b0}}};
    assign port_wdata   = req_wdata;

    //////////////////////////////
    // Control
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= port_idle;
            held_tag  <= '0;
            data_done <= 1'b0;
        end else begin
            data_done <= 1'b0; // Pulse
            case (state)
                port_idle: begin
                    if (data_command != mem_pkg::bus_none) state <= port_requesting;
                end
                port_requesting: begin
                    if (granted) begin
                        if (req_command == mem_pkg::bus_store) begin
                            state     <= port_idle; // Store done at acceptance
                            data_done <= 1'b1;
                        end else begin
                            held_tag <= port_grant_tag;
                            state    <= port_awaiting;
                        end
                    end
                end
                port_awaiting: begin
                    if (data_back) begin
                        state     <= port_idle;
                        held_tag  <= '0;
                        data_done <= 1'b1;
                    end
                end
                default: state <= port_idle;
            endcase
        end
    end

    // Request and load data registers
    always_ff @(posedge clock) begin
        if (state == port_idle && data_command != mem_pkg::bus_none) begin
            req_command <= data_command;
            req_addr    <= data_addr;
            req_wdata   <= data_wdata;
        end
        if (data_back) data_rdata <= return_data; // Held until next load
    end

    // Requester must wait for busy to drop
    no_request_while_busy: assert property (@(posedge clock) disable iff (reset)
        data_busy |-> data_command == mem_pkg::bus_none)
        else $error("data_command %h while data_busy", data_command);

endmodule

/* hw/mem_arbiter.sv */
// Fixed-priority memory arbiter; data port always wins, response tag goes back to the winner only
`timescale 1ns/1ps

module mem_arbiter (
    // Instruction cache side
    input  mem_pkg::mem_command_t icache_command,
    input  mem_pkg::addr_t        icache_addr,
    output mem_pkg::mem_tag_t     icache_grant_tag,

    // Data port side, higher priority
    input  mem_pkg::mem_command_t port_command,
    input  mem_pkg::addr_t        port_addr,
    input  mem_pkg::mem_block_t   port_wdata,
    output mem_pkg::mem_tag_t     port_grant_tag,

    // To memory
    output mem_pkg::mem_command_t mem_command,
    output mem_pkg::addr_t        mem_addr,
    output mem_pkg::mem_block_t   mem_wdata,
    input  mem_pkg::mem_tag_t     mem_response_tag // Same-cycle accept tag
);

    logic data_wins;

    assign data_wins = (port_command != mem_pkg::bus_none);

    //////////////////////////////
    // Request mux
    //////////////////////////////

    assign mem_command = data_wins ? port_command : icache_command;
    assign mem_addr    = data_wins ? port_addr    : icache_addr;
    assign mem_wdata   = port_wdata; // icache never writes

    //////////////////////////////
    // Tag steering
    //////////////////////////////

    // Loser sees zero and retries next cycle
    assign port_grant_tag   = data_wins ? mem_response_tag : '0;
    assign icache_grant_tag = data_wins ? '0 : mem_response_tag;

endmodule

/* hw/tagged_memory.sv */
// Tagged multi-cycle block memory; accepts one command per cycle, returns loads after fixed latency
`timescale 1ns/1ps

module tagged_memory (
    input  logic                  clock,
    input  logic                  reset,

    // Request from arbiter
    input  mem_pkg::mem_command_t mem_command,
    input  mem_pkg::addr_t        mem_addr,
    input  mem_pkg::mem_block_t   mem_wdata,
    output mem_pkg::mem_tag_t     mem_response_tag, // Nonzero on every accepted command

    // Return broadcast to both clients
    output mem_pkg::mem_block_t   return_data,
    output mem_pkg::mem_tag_t     return_tag      // Zero when nothing returns
);

    //////////////////////////////
    // Storage
    //////////////////////////////

    mem_pkg::mem_block_t mem [mem_pkg::mem_depth]; // Contents start undefined

    logic [mem_pkg::mem_index_bits-1:0] block_index; // Higher addr bits alias
    logic                               accept;
    logic                               is_load;

    assign block_index = mem_addr[mem_pkg::block_offset +: mem_pkg::mem_index_bits];
    assign accept      = (mem_command != mem_pkg::bus_none);
    assign is_load     = (mem_command == mem_pkg::bus_load);

    //////////////////////////////
    // Tag allocation
    //////////////////////////////

    mem_pkg::mem_tag_t next_tag; // Rotates 1..15, never zero

    assign mem_response_tag = accept ? next_tag : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag <= 4'd1;
        end else if (accept) begin
            next_tag <= (next_tag == mem_pkg::max_tag) ? 4'd1 : next_tag + 4'd1; // Skip zero
        end
    end

    //////////////////////////////
    // Array access
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (mem_command == mem_pkg::bus_store) mem[block_index] <= mem_wdata; // Write at accept
    end

    //////////////////////////////
    // Return pipeline
    //////////////////////////////

    mem_pkg::mem_tag_t   pipe_tag  [mem_pkg::mem_latency]; // Zero marks an empty stage
    mem_pkg::mem_block_t pipe_data [mem_pkg::mem_latency];

    // Stage 0 loads at accept, last stage shows mem_latency cycles later
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < mem_pkg::mem_latency; i++) begin
                pipe_tag[i] <= '0;
            end
        end else begin
            pipe_tag[0] <= is_load ? mem_response_tag : '0;
            for (int i = 1; i < mem_pkg::mem_latency; i++) begin
                pipe_tag[i] <= pipe_tag[i-1];
            end
        end
    end

    // Payload follows the tags
    always_ff @(posedge clock) begin
        pipe_data[0] <= mem[block_index]; // Read at accept
        for (int i = 1; i < mem_pkg::mem_latency; i++) begin
            pipe_data[i] <= pipe_data[i-1];
        end
    end

    assign return_tag  = pipe_tag[mem_pkg::mem_latency-1];
    assign return_data = pipe_data[mem_pkg::mem_latency-1];

endmodule

/* hw/mem_subsystem.sv */
// Top of the fetch memory subsystem; wires icache and data port through the arbiter to memory
`timescale 1ns/1ps

module mem_subsystem (
    input  logic                  clock,
    input  logic                  reset,

    // Fetch side
    input  mem_pkg::addr_t        fetch_addr,
    output mem_pkg::mem_block_t   fetch_data,
    output logic                  fetch_valid,

    // Data side
    input  mem_pkg::mem_command_t data_command,
    input  mem_pkg::addr_t        data_addr,
    input  mem_pkg::mem_block_t   data_wdata,
    output mem_pkg::mem_block_t   data_rdata,
    output logic                  data_busy,
    output logic                  data_done
);

    //////////////////////////////
    // Client to arbiter
    //////////////////////////////

    mem_pkg::mem_command_t icache_command;
    mem_pkg::addr_t        icache_addr;
    mem_pkg::mem_tag_t     icache_grant_tag;

    mem_pkg::mem_command_t port_command;
    mem_pkg::addr_t        port_addr;
    mem_pkg::mem_block_t   port_wdata;
    mem_pkg::mem_tag_t     port_grant_tag;

    //////////////////////////////
    // Arbiter to memory, return
    //////////////////////////////

    mem_pkg::mem_command_t mem_command;
    mem_pkg::addr_t        mem_addr;
    mem_pkg::mem_block_t   mem_wdata;
    mem_pkg::mem_tag_t     mem_response_tag;
    mem_pkg::mem_block_t   return_data;  // Broadcast to both clients
    mem_pkg::mem_tag_t     return_tag;

    icache i_icache (
        .clock, .reset,
        .fetch_addr, .fetch_data, .fetch_valid,
        .icache_command, .icache_addr, .icache_grant_tag,
        .return_data, .return_tag
    );

    data_port i_data_port (
        .clock, .reset,
        .data_command, .data_addr, .data_wdata,
        .data_rdata, .data_busy, .data_done,
        .port_command, .port_addr, .port_wdata, .port_grant_tag,
        .return_data, .return_tag
    );

    mem_arbiter i_mem_arbiter (
        .icache_command, .icache_addr, .icache_grant_tag,
        .port_command, .port_addr, .port_wdata, .port_grant_tag,
        .mem_command, .mem_addr, .mem_wdata, .mem_response_tag
    );

    tagged_memory i_tagged_memory (
        .clock, .reset,
        .mem_command, .mem_addr, .mem_wdata, .mem_response_tag,
        .return_data, .return_tag
    );

endmodule

/* tests/tb_vectors.svh */
// Vector table for the subsystem testbench, included inside the testbench module body
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

    // Columns: operation, address, store address beside a fetch, fetch_valid in first cycle
    // Store data comes from $random, so rows only name the blocks

    task automatic load_vectors();
        // Fill memory through the data port
        add_vector(op_store, 32'h0000_0048, '0, 1'b0); // Block A, cache index 9, tag 0
        add_vector(op_store, 32'h0000_0148, '0, 1'b0); // Block B, same index, tag 1
        add_vector(op_store, 32'h0000_0090, '0, 1'b0); // Block C
        add_vector(op_store, 32'h0000_0210, '0, 1'b0); // Block D, data side only
        add_vector(op_store, 32'h0000_0420, '0, 1'b0); // Block F
        add_vector(op_store, 32'h0000_0420, '0, 1'b0); // F again, last value counts
        add_vector(op_store, 32'h0000_0528, '0, 1'b0); // Block G
        add_vector(op_store, 32'h0000_0630, '0, 1'b0); // Block H, fetched under traffic
        add_vector(op_load,  32'h0000_0048, '0, 1'b0);
        add_vector(op_load,  32'h0000_0420, '0, 1'b0);
        add_vector(op_load,  32'h0000_0528, '0, 1'b0);
        // Fetch misses, hits and eviction on index 9
        add_vector(op_fetch, 32'h0000_0048, '0, 1'b0); // Cold miss
        add_vector(op_fetch, 32'h0000_0048, '0, 1'b1); // Same address, hit
        add_vector(op_fetch, 32'h0000_0090, '0, 1'b0);
        add_vector(op_fetch, 32'h0000_0048, '0, 1'b1); // Back to A, still cached
        add_vector(op_fetch, 32'h0000_0148, '0, 1'b0); // B evicts A
        add_vector(op_fetch, 32'h0000_0048, '0, 1'b0); // A evicts B
        // Fetch miss racing data traffic
        add_vector(op_fetch_store, 32'h0000_0630, 32'h0000_0528, 1'b0);
        add_vector(op_load,  32'h0000_0420, '0, 1'b0);
        add_vector(op_store, 32'h0000_0210, '0, 1'b0);
        add_vector(op_load,  32'h0000_0210, '0, 1'b0);
        add_vector(op_load,  32'h0000_0528, '0, 1'b0); // Sees the racing store
        add_vector(op_fetch_wait, '0, '0, 1'b0);      // H fill
        add_vector(op_fetch, 32'h0000_0630, '0, 1'b1);
        add_vector(op_load,  32'h0000_0148, '0, 1'b0);
    endtask

`endif

/* tests/tb_mem_subsystem.sv */
// Self-checking testbench for the fetch memory subsystem, runs the vector table against a model
`timescale 1ns/1ps

module tb_mem_subsystem;

    typedef enum {op_store, op_load, op_fetch, op_fetch_store, op_fetch_wait} op_t;

    typedef struct {
        op_t            op;
        mem_pkg::addr_t addr;        // Data or fetch address
        mem_pkg::addr_t store_addr;  // Store beside a fetch
        bit             first_valid; // Expected fetch_valid in first cycle
    } vector_t;

    localparam int entry_cycles = 4 * mem_pkg::mem_latency + 10; // Watchdog share per row
    localparam int wait_limit   = 2 * mem_pkg::mem_latency + 10; // Per-row wait
    localparam int store_cycles = 2; // Request cycle, grant cycle, then done

    logic                  clock;
    logic                  reset;
    mem_pkg::addr_t        fetch_addr;
    mem_pkg::mem_block_t   fetch_data;
    logic                  fetch_valid;
    mem_pkg::mem_command_t data_command;
    mem_pkg::addr_t        data_addr;
    mem_pkg::mem_block_t   data_wdata;
    mem_pkg::mem_block_t   data_rdata;
    logic                  data_busy;
    logic                  data_done;

    vector_t               vectors [$];
    mem_pkg::mem_block_t   model [logic [7:0]]; // Indexed by addr bits 10..3
    mem_pkg::mem_command_t issued_command;      // Data request in flight
    mem_pkg::addr_t        issued_addr;
    int                    seed   = 38;
    int                    errors = 0;
    int                    checks = 0;

    mem_subsystem i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic add_vector(input op_t op, input mem_pkg::addr_t addr,
                              input mem_pkg::addr_t store_addr, input bit first_valid);
        vector_t v;
        v.op          = op;
        v.addr        = addr;
        v.store_addr  = store_addr;
        v.first_valid = first_valid;
        vectors.push_back(v);
    endtask

    `include "tb_vectors.svh"

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    //////////////////////////////
    // Data and fetch steps
    //////////////////////////////

    task automatic start_data(input mem_pkg::mem_command_t command, input mem_pkg::addr_t addr);
        mem_pkg::mem_block_t wdata;
        wdata          = {$random(seed), $random(seed)};
        issued_command = command;
        issued_addr    = addr;
        data_command  <= command;
        data_addr     <= addr;
        data_wdata    <= wdata;
        if (command == mem_pkg::bus_store) model[addr[10:3]] = wdata; // Written at acceptance
    endtask

    task automatic finish_data(input int entry);
        int cycles;
        cycles = 1;
        @(posedge clock);
        data_command <= mem_pkg::bus_none; // One-cycle strobe
        @(negedge clock);
        check_value("data_busy", data_busy, 1'b1);
        while (!data_done && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        if (!data_done) begin
            note_failure($sformatf("Row %0d: data port never signalled done", entry));
        end else if (issued_command == mem_pkg::bus_store) begin
            check_value("data_done cycle", cycles, store_cycles); // Data side always wins
        end else begin
            check_value("data_rdata", data_rdata, model[issued_addr[10:3]]);
        end
    endtask

    task automatic finish_fetch(input int entry);
        int cycles;
        cycles = 0;
        while (!fetch_valid && cycles < wait_limit) begin // Miss length varies
            @(negedge clock);
            cycles++;
        end
        if (!fetch_valid) note_failure($sformatf("Row %0d: fetch never became valid", entry));
        else check_value("fetch_data", fetch_data, model[fetch_addr[10:3]]);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        vector_t v;
        reset        = 1'b1;
        fetch_addr   = '0; // Its block 0 line is never checked
        data_command = mem_pkg::bus_none;
        data_addr    = '0;
        data_wdata   = '0;
        load_vectors();
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("fetch_valid", fetch_valid, 1'b0);
        check_value("data_busy", data_busy, 1'b0);
        check_value("data_done", data_done, 1'b0);
        for (int i = 0; i < vectors.size(); i++) begin
            v = vectors[i];
            @(posedge clock);
            if (v.op == op_fetch || v.op == op_fetch_store) fetch_addr <= v.addr;
            if (v.op == op_store) start_data(mem_pkg::bus_store, v.addr);
            if (v.op == op_load) start_data(mem_pkg::bus_load, v.addr);
            if (v.op == op_fetch_store) start_data(mem_pkg::bus_store, v.store_addr);
            @(negedge clock); // First cycle
            if (v.op == op_fetch || v.op == op_fetch_store)
                check_value("fetch_valid", fetch_valid, v.first_valid);
            if (v.op == op_store || v.op == op_load || v.op == op_fetch_store) finish_data(i);
            if (v.op == op_fetch || v.op == op_fetch_wait) finish_fetch(i);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) $display("All tests passed!");
        else $display("Test failures found");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        int limit;
        @(negedge reset);
        limit = vectors.size() * entry_cycles;
        repeat (limit) @(posedge clock);
        $display("Watchdog expired, tests still running after %0d cycles", limit);
        $display("Test failures found");
        $finish;
    end

endmodule

/* flist.f */
hw/mem_pkg.sv
hw/icache.sv
hw/data_port.sv
hw/mem_arbiter.sv
hw/tagged_memory.sv
hw/mem_subsystem.sv
+incdir+tests
tests/tb_mem_subsystem.sv
